// ==== verilog/tiny_cpu_macros.svh ====
// tiny cpu constants
`ifndef TINY_CPU_MACROS_SVH
`define TINY_CPU_MACROS_SVH

// ##############################
// opcodes
// ##############################
`define OP_OUT    7'd1
`define OP_OUTLOC 7'd2
`define OP_LI     7'd3
`define OP_OUTR   7'd4
`define OP_HALT   7'd5

// ##############################
// memory
// ##############################
`define MEM_WORDS     64
`define MEM_ADDR_BITS 6

// ##############################
// instruction fields
// ##############################
`define IMM_HI 31
`define IMM_LO 25
`define RD_HI  11
`define RD_LO  7

`endif

// ==== verilog/tiny_cpu_pkg.sv ====
// tiny cpu types
`default_nettype none

package tiny_cpu_pkg;

    // data and instruction words
    typedef logic [31:0] word_t;

    // byte-free word address
    typedef logic [31:0] addr_t;

    // register file index
    typedef logic [4:0] reg_idx_t;

    // low opcode field of an instruction
    typedef logic [6:0] opcode_t;

    // memory wait states before ack
    typedef logic [3:0] wait_t;

    // core sequencing
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DATA,
        HALTED
    } core_state_t;

endpackage

`default_nettype wire

// ==== verilog/tiny_cpu_regfile.sv ====
// tiny cpu register file
`default_nettype none

module tiny_cpu_regfile (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wr_en,
    input  tiny_cpu_pkg::reg_idx_t  wr_idx,
    input  tiny_cpu_pkg::word_t     wr_data,
    input  tiny_cpu_pkg::reg_idx_t  rd_idx,
    output tiny_cpu_pkg::word_t     rd_data
);

    localparam int NUM_REGS = 2 ** $bits(tiny_cpu_pkg::reg_idx_t);

    tiny_cpu_pkg::word_t regs [NUM_REGS];

    // unwritten registers read as zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd_data = regs[rd_idx];

endmodule

`default_nettype wire

// ==== verilog/tiny_cpu_mem.sv ====
// tiny cpu word memory
`default_nettype none
`include "tiny_cpu_macros.svh"

module tiny_cpu_mem (
    input  wire                  clk,
    input  wire                  rst,
    input  tiny_cpu_pkg::addr_t  addr,
    input  wire                  rd_req,
    input  wire                  load_en,
    input  tiny_cpu_pkg::addr_t  load_addr,
    input  tiny_cpu_pkg::word_t  load_data,
    input  tiny_cpu_pkg::wait_t  wait_states,
    output tiny_cpu_pkg::word_t  rd_data,
    output logic                 ack,
    output logic                 busy
);

    tiny_cpu_pkg::word_t mem [`MEM_WORDS];

    logic [`MEM_ADDR_BITS-1:0] addr_q;
    logic [`MEM_ADDR_BITS-1:0] rd_idx;
    tiny_cpu_pkg::wait_t       count;
    logic                      accept;
    logic                      fire;

    assign accept = rd_req && !busy;

    // ack next edge when idle with no wait, or when countdown is done
    assign fire = (busy && (count == '0)) || (accept && (wait_states == '0));

    // a zero-wait read uses the live address
    assign rd_idx = busy ? addr_q : addr[`MEM_ADDR_BITS-1:0];

    // ##############################
    // wait-state countdown
    // ##############################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            ack   <= 1'b0;
            count <= '0;
        end else begin
            ack <= fire;
            if (busy) begin
                if (count == '0) begin
                    busy <= 1'b0;
                end else begin
                    count <= count - 1'b1;
                end
            end else if (accept && (wait_states != '0)) begin
                busy  <= 1'b1;
                count <= wait_states - 1'b1;
            end
        end
    end

    // ##############################
    // storage
    // ##############################
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[`MEM_ADDR_BITS-1:0]] <= load_data;
        end
        if (accept) begin
            addr_q <= addr[`MEM_ADDR_BITS-1:0];
        end
        if (fire) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tiny_cpu_ctrl.sv ====
// tiny cpu control block
`default_nettype none

module tiny_cpu_ctrl (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  start,
    input  wire                  cfg_wr,
    input  tiny_cpu_pkg::wait_t  cfg_wait,
    input  wire                  halt,
    input  wire                  out_valid,
    output logic                 launch,
    output tiny_cpu_pkg::wait_t  wait_states,
    output logic                 halted,
    output tiny_cpu_pkg::word_t  out_count
);

    logic running;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            launch      <= 1'b0;
            running     <= 1'b0;
            halted      <= 1'b0;
            wait_states <= '0;
            out_count   <= '0;
        end else begin
            launch <= 1'b0;

            if (cfg_wr) begin
                wait_states <= cfg_wait;
            end

            // starts while running are dropped
            if (start && !running) begin
                launch  <= 1'b1;
                running <= 1'b1;
            end else if (halt) begin
                running <= 1'b0;
            end

            if (launch) begin
                halted    <= 1'b0;
                out_count <= '0;
            end else begin
                if (halt) begin
                    halted <= 1'b1;
                end
                if (out_valid) begin
                    out_count <= out_count + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tiny_cpu_core.sv ====
// tiny cpu core
`default_nettype none
`include "tiny_cpu_macros.svh"

module tiny_cpu_core (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     launch,
    input  tiny_cpu_pkg::word_t     mem_rd_data,
    input  wire                     mem_ack,
    input  wire                     mem_busy,
    input  tiny_cpu_pkg::word_t     rf_rd_data,
    output tiny_cpu_pkg::addr_t     mem_addr,
    output logic                    mem_rd_req,
    output logic                    rf_wr_en,
    output tiny_cpu_pkg::reg_idx_t  rf_wr_idx,
    output tiny_cpu_pkg::word_t     rf_wr_data,
    output tiny_cpu_pkg::reg_idx_t  rf_rd_idx,
    output tiny_cpu_pkg::word_t     out_data,
    output logic                    out_valid,
    output logic                    halt,
    output tiny_cpu_pkg::addr_t     pc
);

    tiny_cpu_pkg::core_state_t state;

    // request waiting for the memory to go idle
    logic req_pend;

    tiny_cpu_pkg::opcode_t     fetch_op;
    tiny_cpu_pkg::reg_idx_t    fetch_rd;
    tiny_cpu_pkg::word_t       fetch_imm;
    logic                      fetch_ack;
    logic                      data_ack;

    // ##############################
    // decode
    // ##############################
    assign fetch_op  = mem_rd_data[$bits(tiny_cpu_pkg::opcode_t)-1:0];
    assign fetch_rd  = mem_rd_data[`RD_HI:`RD_LO];
    assign fetch_imm = {{(32 - (`IMM_HI - `IMM_LO + 1)){1'b0}}, mem_rd_data[`IMM_HI:`IMM_LO]};

    assign fetch_ack = (state == tiny_cpu_pkg::FETCH) && mem_ack;
    assign data_ack  = (state == tiny_cpu_pkg::DATA) && mem_ack;

    // OUTR reads the register named in the word being acked
    assign rf_rd_idx = fetch_rd;

    // hold requests off while the memory counts wait states
    assign mem_rd_req = req_pend && !mem_busy;

    // ##############################
    // sequencing
    // ##############################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= tiny_cpu_pkg::IDLE;
            pc        <= '0;
            mem_addr  <= '0;
            req_pend  <= 1'b0;
            out_valid <= 1'b0;
            halt      <= 1'b0;
            rf_wr_en  <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            halt      <= 1'b0;
            rf_wr_en  <= 1'b0;
            if (mem_rd_req) begin
                req_pend <= 1'b0;
            end

            case (state)
                tiny_cpu_pkg::IDLE,
                tiny_cpu_pkg::HALTED: begin
                    if (launch) begin
                        state    <= tiny_cpu_pkg::FETCH;
                        pc       <= '0;
                        mem_addr <= '0;
                        req_pend <= 1'b1;
                    end
                end

                tiny_cpu_pkg::FETCH: begin
                    if (mem_ack) begin
                        case (fetch_op)
                            `OP_OUT,
                            `OP_OUTR: begin
                                out_valid <= 1'b1;
                                pc        <= pc + 1'b1;
                                mem_addr  <= pc + 1'b1;
                                req_pend  <= 1'b1;
                            end
                            `OP_LI: begin
                                rf_wr_en <= 1'b1;
                                pc       <= pc + 1'b1;
                                mem_addr <= pc + 1'b1;
                                req_pend <= 1'b1;
                            end
                            `OP_OUTLOC: begin
                                // word index from imm bits 6:2
                                mem_addr <= {27'd0, fetch_imm[6:2]};
                                req_pend <= 1'b1;
                                state    <= tiny_cpu_pkg::DATA;
                            end
                            default: begin
                                // HALT and anything unknown
                                halt  <= 1'b1;
                                state <= tiny_cpu_pkg::HALTED;
                            end
                        endcase
                    end
                end

                tiny_cpu_pkg::DATA: begin
                    if (data_ack) begin
                        out_valid <= 1'b1;
                        pc        <= pc + 1'b1;
                        mem_addr  <= pc + 1'b1;
                        req_pend  <= 1'b1;
                        state     <= tiny_cpu_pkg::FETCH;
                    end
                end

                default: begin
                    state <= tiny_cpu_pkg::IDLE;
                end
            endcase
        end
    end

    // ##############################
    // result and register write data
    // ##############################
    always_ff @(posedge clk) begin
        if (fetch_ack) begin
            rf_wr_idx  <= fetch_rd;
            rf_wr_data <= fetch_imm;
            if (fetch_op == `OP_OUTR) begin
                out_data <= rf_rd_data;
            end else begin
                out_data <= fetch_imm;
            end
        end else if (data_ack) begin
            out_data <= mem_rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tiny_cpu_top.sv ====
// tiny cpu subsystem
`default_nettype none

module tiny_cpu_top (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  start,
    input  wire                  cfg_wr,
    input  tiny_cpu_pkg::wait_t  cfg_wait,
    input  wire                  load_en,
    input  tiny_cpu_pkg::addr_t  load_addr,
    input  tiny_cpu_pkg::word_t  load_data,
    output tiny_cpu_pkg::word_t  out_data,
    output wire                  out_valid,
    output wire                  halted,
    output tiny_cpu_pkg::word_t  out_count,
    output tiny_cpu_pkg::addr_t  pc
);

    // core to memory
    tiny_cpu_pkg::addr_t    mem_addr;
    tiny_cpu_pkg::word_t    mem_rd_data;
    wire                    mem_rd_req;
    wire                    mem_ack;
    wire                    mem_busy;

    // core to register file
    wire                    rf_wr_en;
    tiny_cpu_pkg::reg_idx_t rf_wr_idx;
    tiny_cpu_pkg::word_t    rf_wr_data;
    tiny_cpu_pkg::reg_idx_t rf_rd_idx;
    tiny_cpu_pkg::word_t    rf_rd_data;

    // control
    wire                    launch;
    wire                    halt;
    tiny_cpu_pkg::wait_t    wait_states;

    tiny_cpu_core core_i (
        .clk         (clk),
        .rst         (rst),
        .launch      (launch),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .mem_busy    (mem_busy),
        .rf_rd_data  (rf_rd_data),
        .mem_addr    (mem_addr),
        .mem_rd_req  (mem_rd_req),
        .rf_wr_en    (rf_wr_en),
        .rf_wr_idx   (rf_wr_idx),
        .rf_wr_data  (rf_wr_data),
        .rf_rd_idx   (rf_rd_idx),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .halt        (halt),
        .pc          (pc)
    );

    tiny_cpu_regfile regfile_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (rf_wr_en),
        .wr_idx  (rf_wr_idx),
        .wr_data (rf_wr_data),
        .rd_idx  (rf_rd_idx),
        .rd_data (rf_rd_data)
    );

    tiny_cpu_mem mem_i (
        .clk         (clk),
        .rst         (rst),
        .addr        (mem_addr),
        .rd_req      (mem_rd_req),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .wait_states (wait_states),
        .rd_data     (mem_rd_data),
        .ack         (mem_ack),
        .busy        (mem_busy)
    );

    tiny_cpu_ctrl ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cfg_wr      (cfg_wr),
        .cfg_wait    (cfg_wait),
        .halt        (halt),
        .out_valid   (out_valid),
        .launch      (launch),
        .wait_states (wait_states),
        .halted      (halted),
        .out_count   (out_count)
    );

endmodule

`default_nettype wire

// ==== dv/tiny_cpu_tb.sv ====
// tiny cpu testbench
`default_nettype none

module tiny_cpu_tb;

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic                  cfg_wr;
    tiny_cpu_pkg::wait_t   cfg_wait;
    logic                  load_en;
    tiny_cpu_pkg::addr_t   load_addr;
    tiny_cpu_pkg::word_t   load_data;
    tiny_cpu_pkg::word_t   out_data;
    wire                   out_valid;
    wire                   halted;
    tiny_cpu_pkg::word_t   out_count;
    tiny_cpu_pkg::addr_t   pc;

    tiny_cpu_pkg::word_t   exp_q[$];
    tiny_cpu_pkg::word_t   obs_q[$];
    int                    errors;
    int                    checks;
    int                    limit_cycles;
    string                 test_name;

    // host copy of the loaded memory words
    tiny_cpu_pkg::word_t   image [64];

    tiny_cpu_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cfg_wr    (cfg_wr),
        .cfg_wait  (cfg_wait),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halted    (halted),
        .out_count (out_count),
        .pc        (pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // outputs are registered, sampled away from the rising edge
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            obs_q.push_back(out_data);
        end
    end

    // ##############################
    // helpers
    // ##############################
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input tiny_cpu_pkg::word_t exp_v,
                               input tiny_cpu_pkg::word_t act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("** Error [%0s]: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    // address of the first word whose opcode is not one of the four that continue
    function automatic tiny_cpu_pkg::addr_t halt_addr();
        tiny_cpu_pkg::addr_t   a;
        tiny_cpu_pkg::opcode_t op;
        a = '0;
        op = image[0][6:0];
        while (a < 63 && op >= 7'd1 && op <= 7'd4) begin
            a++;
            op = image[a[5:0]][6:0];
        end
        return a;
    endfunction

    task automatic finish_run();
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // timeout from the number of expected results and the longest wait
    task automatic size_run(input int fd);
        string tok;
        string line;
        int    code;
        int    n_res;
        int    max_wait;
        int    w;
        n_res = 0;
        max_wait = 0;
        while (!$feof(fd)) begin
            tok = "";
            code = $fscanf(fd, " %s", tok);
            if (code != 1) begin
                break;
            end
            code = $fgets(line, fd);
            if (tok == "E" || tok == "H") begin
                n_res++;
            end else if (tok == "W") begin
                code = $sscanf(line, "%h", w);
                if (w > max_wait) begin
                    max_wait = w;
                end
            end
        end
        limit_cycles = 200 * n_res * (max_wait + 4);
    endtask

    task automatic start_test(input string name, input int extra);
        test_name = name;
        exp_q.delete();
        obs_q.delete();
        start = 1'b1;
        tick();
        start = 1'b0;
        // launch, then running is set
        tick();
        tick();
        for (int i = 0; i < extra; i++) begin
            // restart attempt once the program has emitted a word
            while (obs_q.size() == 0) begin
                tick();
            end
            start = 1'b1;
            tick();
            start = 1'b0;
            tick();
        end
    endtask

    task automatic end_test(input tiny_cpu_pkg::word_t exp_count);
        while (halted !== 1'b1) begin
            tick();
        end
        tick();
        if (obs_q.size() != exp_q.size()) begin
            errors++;
            $display("test %0s emitted %0d words but %0d were expected",
                     test_name, obs_q.size(), exp_q.size());
        end
        for (int i = 0; i < exp_q.size() && i < obs_q.size(); i++) begin
            check_value($sformatf("%0s out %0d", test_name, i), exp_q[i], obs_q[i]);
        end
        check_value({test_name, " out_count"}, exp_count, out_count);
        check_value({test_name, " pc"}, halt_addr(), pc);
    endtask

    // ##############################
    // watchdog
    // ##############################
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog: run did not end within %0d cycles", limit_cycles);
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("=== FAIL ===");
        $finish;
    end

    // ##############################
    // pattern replay
    // ##############################
    initial begin
        int                  fd;
        int                  code;
        string               tok;
        string               line;
        string               name;
        int                  extra;
        tiny_cpu_pkg::word_t a;
        tiny_cpu_pkg::word_t d;

        rst = 1'b1;
        start = 1'b0;
        cfg_wr = 1'b0;
        cfg_wait = '0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        errors = 0;
        checks = 0;
        limit_cycles = 0;
        test_name = "";

        fd = $fopen("dv/tiny_cpu_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file dv/tiny_cpu_patterns.txt");
            $display("=== FAIL ===");
            $finish;
        end else begin
            size_run(fd);
            $fclose(fd);
            fd = $fopen("dv/tiny_cpu_patterns.txt", "r");

            repeat (16) @(posedge clk);
            #1;
            rst = 1'b0;
            tick();

            while (!$feof(fd)) begin
                tok = "";
                code = $fscanf(fd, " %s", tok);
                if (code != 1) begin
                    break;
                end
                if (tok == "L") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    image[a[5:0]] = d;
                    load_en = 1'b1;
                    load_addr = a;
                    load_data = d;
                    tick();
                    load_en = 1'b0;
                end else if (tok == "W") begin
                    code = $fscanf(fd, "%h", a);
                    cfg_wr = 1'b1;
                    cfg_wait = a[3:0];
                    tick();
                    cfg_wr = 1'b0;
                end else if (tok == "S") begin
                    code = $fscanf(fd, "%s %d", name, extra);
                    start_test(name, extra);
                end else if (tok == "E") begin
                    code = $fscanf(fd, "%h", d);
                    exp_q.push_back(d);
                end else if (tok == "H") begin
                    code = $fscanf(fd, "%h", d);
                    end_test(d);
                end else if (tok == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    errors++;
                    $display("unknown record %0s in the pattern file", tok);
                    code = $fgets(line, fd);
                end
            end
            $fclose(fd);
            finish_run();
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+verilog
verilog/tiny_cpu_pkg.sv
verilog/tiny_cpu_regfile.sv
verilog/tiny_cpu_mem.sv
verilog/tiny_cpu_ctrl.sv
verilog/tiny_cpu_core.sv
verilog/tiny_cpu_top.sv
dv/tiny_cpu_tb.sv

// ==== Makefile ====
# Verilator build for the tiny cpu testbench

OBJ = obj_dir
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing -f all.f --top-module tiny_cpu_tb -Mdir $(OBJ)

run: compile
	./$(OBJ)/Vtiny_cpu_tb | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ) $(LOG)

// ==== dv/tiny_cpu_patterns.txt ====
# rec L addr data | W wait | S name extra_starts | E out_data | H out_count
# all numbers in hex
L 10 DEADBEEF
L 0 0A000001
L 1 FE000001
L 2 AA000183
L 3 00000184
L 4 00000484
L 5 86000002
L 6 00000005
W 0
S mixed_w0 0
E 5
E 7F
E 55
E 0
E DEADBEEF
H 5
W 3
S mixed_w3 0
E 5
E 7F
E 55
E 0
E DEADBEEF
H 5
W F
S mixed_w15 0
E 5
E 7F
E 55
E 0
E DEADBEEF
H 5
L 3 0000007F
W 2
S unknown_op 0
E 5
E 7F
H 2
S rerun 0
E 5
E 7F
H 2
L 3 00000184
W 3
S start_busy 1
E 5
E 7F
E 55
E 0
E DEADBEEF
H 5
